// ==== source/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addiu = 6'h09,
        op_lui   = 6'h0f,
        op_cop0  = 6'h10,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // eret shares the function field position under the cop0 opcode.
    typedef enum logic [5:0] {
        fn_eret = 6'h18,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction field positions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int op_hi     = 31;
    localparam int op_lo     = 26;
    localparam int rs_hi     = 25;
    localparam int rs_lo     = 21;
    localparam int rt_hi     = 20;
    localparam int rt_lo     = 16;
    localparam int rd_hi     = 15;
    localparam int rd_lo     = 11;
    localparam int imm_hi    = 15;
    localparam int imm_lo    = 0;
    localparam int funct_hi  = 5;
    localparam int funct_lo  = 0;
    localparam int target_hi = 25;
    localparam int target_lo = 0;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;
    import isa_pkg::*;

    localparam word_t reset_vector     = 32'h0000_0000;
    localparam word_t interrupt_vector = 32'h0000_0100;
    localparam int    int_lines        = 5;
    localparam int    int_sync_depth   = 2;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jump
    } branch_t;

    typedef enum logic [1:0] {
        fwd_rf,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instruction;
    } fetch_reg_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_t  alu_op;
        word_t    a_val;
        word_t    b_val;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    imm;
        logic     imm_sel;
        reg_idx_t dest;
        logic     write_reg;
        logic     mem_read;
        logic     mem_write;
        branch_t  branch;
        word_t    target;
        logic     is_eret;
    } decode_reg_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    result;
        word_t    store_data;
        reg_idx_t dest;
        logic     write_reg;
        logic     mem_read;
        logic     mem_write;
        logic     is_eret;
    } execute_reg_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    data;
        logic     write_reg;
    } memory_reg_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } data_req_t;

endpackage

// ==== source/stage_fetch.sv ====
`timescale 1ns/1ps

module stage_fetch
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       flush,
    input  logic       load,
    input  word_t      pc_in,
    output word_t      instr_addr,
    input  word_t      instr_data,
    output fetch_reg_t fetch_out
);

    word_t pc_q;

    assign instr_addr = pc_q;

    // a redirect always wins over a hold of the front end.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= reset_vector;
        end else if (load) begin
            pc_q <= pc_in;
        end else if (!stall) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_out.valid <= 1'b0;
        end else if (!stall) begin
            fetch_out.valid       <= !flush;
            fetch_out.pc          <= pc_q;
            fetch_out.instruction <= instr_data;
        end
    end

endmodule

// ==== source/stage_decode.sv ====
`timescale 1ns/1ps

module stage_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        flush,
    input  fetch_reg_t  fetch_in,
    input  memory_reg_t wb_in,
    output decode_reg_t decode_out
);

    word_t       regs [32];
    word_t       instr;
    word_t       pc_plus4;
    word_t       simm;
    opcode_t     opcode;
    funct_t      funct;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic        wb_write;
    decode_reg_t next;

    assign instr    = fetch_in.instruction;
    assign opcode   = opcode_t'(instr[op_hi:op_lo]);
    assign funct    = funct_t'(instr[funct_hi:funct_lo]);
    assign rs       = instr[rs_hi:rs_lo];
    assign rt       = instr[rt_hi:rt_lo];
    assign rd       = instr[rd_hi:rd_lo];
    assign simm     = {{16{instr[imm_hi]}}, instr[imm_hi:imm_lo]};
    assign pc_plus4 = fetch_in.pc + 32'd4;
    assign wb_write = wb_in.valid && wb_in.write_reg;

    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[wb_in.dest] <= wb_in.data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next           = '0;
        next.valid     = fetch_in.valid;
        next.pc        = fetch_in.pc;
        next.alu_op    = alu_add;
        next.rs        = rs;
        next.rt        = rt;
        next.imm       = simm;
        next.dest      = rd;
        next.branch    = br_none;
        next.target    = pc_plus4 + (simm << 2);

        // the write port is passed through to a read in the same cycle.
        if (rs == '0) next.a_val = '0;
        else if (wb_write && wb_in.dest == rs) next.a_val = wb_in.data;
        else next.a_val = regs[rs];
        if (rt == '0) next.b_val = '0;
        else if (wb_write && wb_in.dest == rt) next.b_val = wb_in.data;
        else next.b_val = regs[rt];

        case (opcode)
            op_rtype: begin
                next.write_reg = 1'b1;
                case (funct)
                    fn_addu: next.alu_op = alu_add;
                    fn_subu: next.alu_op = alu_sub;
                    fn_and:  next.alu_op = alu_and;
                    fn_or:   next.alu_op = alu_or;
                    fn_slt:  next.alu_op = alu_slt;
                    default: next.write_reg = 1'b0;
                endcase
            end
            op_addiu, op_lui, op_lw: begin
                next.imm_sel   = 1'b1;
                next.dest      = rt;
                next.write_reg = 1'b1;
                next.mem_read  = (opcode == op_lw);
                if (opcode == op_lui) next.alu_op = alu_lui;
            end
            op_sw: begin
                next.imm_sel   = 1'b1;
                next.mem_write = 1'b1;
            end
            op_beq: next.branch = br_beq;
            op_bne: next.branch = br_bne;
            op_j: begin
                next.branch = br_jump;
                next.target = {pc_plus4[31:28], instr[target_hi:target_lo], 2'b00};
            end
            op_cop0: next.is_eret = (funct == fn_eret);
            default: ;
        endcase

        next.write_reg = next.write_reg && fetch_in.valid && (next.dest != '0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_out.valid <= 1'b0;
        end else if (!stall) begin
            decode_out       <= next;
            decode_out.valid <= next.valid && !flush;
        end
    end

    // write-back arrives from the memory stage register.
    assert property (@(posedge clk) disable iff (reset)
        wb_in.valid && wb_in.write_reg |-> wb_in.dest != '0)
        else $error("write-back targets register 0");

endmodule

// ==== source/stage_execute.sv ====
`timescale 1ns/1ps

module stage_execute
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         stall,
    input  decode_reg_t  decode_in,
    input  fwd_sel_t     fwd_a,
    input  fwd_sel_t     fwd_b,
    input  execute_reg_t mem_fwd,
    input  memory_reg_t  wb_fwd,
    output logic         redirect,
    output word_t        target,
    output execute_reg_t execute_out
);

    word_t a;
    word_t b_reg;
    word_t b;
    word_t result;
    logic  taken;

    always_comb begin
        case (fwd_a)
            fwd_mem: a = mem_fwd.result;
            fwd_wb:  a = wb_fwd.data;
            default: a = decode_in.a_val;
        endcase
        case (fwd_b)
            fwd_mem: b_reg = mem_fwd.result;
            fwd_wb:  b_reg = wb_fwd.data;
            default: b_reg = decode_in.b_val;
        endcase
        b = decode_in.imm_sel ? decode_in.imm : b_reg;

        case (decode_in.alu_op)
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: result = {31'd0, $signed(a) < $signed(b)};
            alu_lui: result = {b[15:0], 16'h0000};
            default: result = a + b;
        endcase

        case (decode_in.branch)
            br_beq:  taken = (a == b_reg);
            br_bne:  taken = (a != b_reg);
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = decode_in.valid && taken;
    assign target   = decode_in.target;

    always_ff @(posedge clk) begin
        if (reset) begin
            execute_out.valid <= 1'b0;
        end else if (!stall) begin
            execute_out.valid      <= decode_in.valid;
            execute_out.pc         <= decode_in.pc;
            execute_out.result     <= result;
            execute_out.store_data <= b_reg;
            execute_out.dest       <= decode_in.dest;
            execute_out.write_reg  <= decode_in.write_reg && decode_in.valid;
            execute_out.mem_read   <= decode_in.mem_read;
            execute_out.mem_write  <= decode_in.mem_write;
            execute_out.is_eret    <= decode_in.is_eret;
        end
    end

    // a redirect held by a stall stays with its instruction until an older redirect kills it.
    assert property (@(posedge clk) disable iff (reset)
        redirect && stall |=> $stable(target) && (redirect || !decode_in.valid))
        else $error("redirect lost while stalled");

endmodule

// ==== source/stage_memory.sv ====
`timescale 1ns/1ps

module stage_memory
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         stall,
    input  logic         cancel,
    input  execute_reg_t execute_in,
    output data_req_t    data_req,
    input  word_t        data_rdata,
    output memory_reg_t  memory_out
);

    logic live;

    assign live = execute_in.valid && !cancel;

    assign data_req.valid = live && (execute_in.mem_read || execute_in.mem_write);
    assign data_req.write = execute_in.mem_write;
    assign data_req.addr  = execute_in.result;
    assign data_req.wdata = execute_in.store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            memory_out.valid <= 1'b0;
        end else if (!stall) begin
            memory_out.valid     <= live;
            memory_out.dest      <= execute_in.dest;
            memory_out.write_reg <= execute_in.write_reg && live;
            memory_out.data      <= execute_in.mem_read ? data_rdata : execute_in.result;
        end
    end

    // the stall here is the data memory back-pressure.
    assert property (@(posedge clk) disable iff (reset)
        data_req.valid && stall |=> $stable(data_req))
        else $error("data request changed under busy");

endmodule

// ==== source/main_forwarder.sv ====
`timescale 1ns/1ps

module main_forwarder
    import pipe_pkg::*;
(
    input  decode_reg_t  decode_in,
    input  execute_reg_t mem_stage,
    input  memory_reg_t  wb_stage,
    output fwd_sel_t     fwd_a,
    output fwd_sel_t     fwd_b
);

    logic mem_ok;
    logic wb_ok;

    // register 0 is constant and never comes from a producer.
    assign mem_ok = mem_stage.valid && mem_stage.write_reg && (mem_stage.dest != '0);
    assign wb_ok  = wb_stage.valid && wb_stage.write_reg && (wb_stage.dest != '0);

    always_comb begin
        if (mem_ok && mem_stage.dest == decode_in.rs) fwd_a = fwd_mem;
        else if (wb_ok && wb_stage.dest == decode_in.rs) fwd_a = fwd_wb;
        else fwd_a = fwd_rf;

        if (mem_ok && mem_stage.dest == decode_in.rt) fwd_b = fwd_mem;
        else if (wb_ok && wb_stage.dest == decode_in.rt) fwd_b = fwd_wb;
        else fwd_b = fwd_rf;
    end

endmodule

// ==== source/pipeline_flow_controller.sv ====
`timescale 1ns/1ps

module pipeline_flow_controller
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  fetch_reg_t   fetch_in,
    input  decode_reg_t  decode_in,
    input  logic         redirect,
    input  word_t        target,
    input  execute_reg_t mem_stage,
    input  logic         data_busy,
    input  logic         int_pending,
    output logic         int_accept,
    output logic         stall_front,
    output logic         stall_all,
    output logic         flush_young,
    output logic         flush_mem,
    output logic         load_pc,
    output word_t        pc_value
);

    word_t    epc_q;
    logic     in_handler_q;
    logic     stall_q;
    logic     eret_taken;
    logic     load_use;
    reg_idx_t fetch_rs;
    reg_idx_t fetch_rt;

    assign fetch_rs  = fetch_in.instruction[rs_hi:rs_lo];
    assign fetch_rt  = fetch_in.instruction[rt_hi:rt_lo];
    assign stall_all = data_busy;

    assign load_use = fetch_in.valid && decode_in.valid && decode_in.mem_read &&
                      decode_in.write_reg &&
                      (decode_in.dest == fetch_rs || decode_in.dest == fetch_rt);

    // an access held by busy last cycle is not cancelled, so its request stays put.
    assign int_accept = int_pending && mem_stage.valid && !in_handler_q &&
                        !data_busy && !stall_q;
    assign eret_taken = mem_stage.valid && mem_stage.is_eret && !data_busy;

    always_comb begin
        if (int_accept) pc_value = interrupt_vector;
        else if (eret_taken) pc_value = epc_q;
        else pc_value = target;
    end

    assign flush_mem   = int_accept || eret_taken;
    assign load_pc     = flush_mem || (redirect && !data_busy);
    assign flush_young = load_pc;
    assign stall_front = load_use && !load_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_handler_q <= 1'b0;
            stall_q      <= 1'b0;
        end else begin
            stall_q <= stall_all;
            if (int_accept) in_handler_q <= 1'b1;
            else if (eret_taken) in_handler_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (int_accept) epc_q <= mem_stage.pc;
    end

    // an eret only returns from a handler that an accepted interrupt entered.
    assert property (@(posedge clk) disable iff (reset)
        eret_taken |-> in_handler_q)
        else $error("eret taken outside the handler");

endmodule

// ==== source/interrupt_storage.sv ====
`timescale 1ns/1ps

module interrupt_storage
    import pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  logic [int_lines-1:0] lines_in,
    output logic                 pending
);

    logic [int_sync_depth-1:0][int_lines-1:0] sync_q;
    logic [int_lines-1:0] last_q;
    logic [int_lines-1:0] hold_q;
    logic [int_lines-1:0] rise;

    // only a new rising level is kept, so a line held high fires once.
    assign rise    = sync_q[int_sync_depth-1] & ~last_q;
    assign pending = |(hold_q | rise);

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= '0;
            last_q <= '0;
            hold_q <= '0;
        end else begin
            sync_q <= {sync_q[int_sync_depth-2:0], lines_in};
            last_q <= sync_q[int_sync_depth-1];
            hold_q <= clear ? '0 : (hold_q | rise);
        end
    end

endmodule

// ==== source/core.sv ====
`timescale 1ns/1ps

module core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [int_lines-1:0] external_interrupt,
    output word_t                instr_addr,
    input  word_t                instr_data,
    output data_req_t            data_req,
    input  word_t                data_rdata,
    input  logic                 data_busy
);

    fetch_reg_t   fetch_q;
    decode_reg_t  decode_q;
    decode_reg_t  execute_in;
    execute_reg_t execute_q;
    memory_reg_t  memory_q;
    fwd_sel_t     fwd_a;
    fwd_sel_t     fwd_b;
    logic         redirect;
    word_t        target;
    logic         stall_front;
    logic         stall_all;
    logic         flush_young;
    logic         flush_mem;
    logic         load_pc;
    word_t        pc_value;
    logic         int_pending;
    logic         int_accept;

    // a redirect from the memory stage also kills the instruction in execute.
    always_comb begin
        execute_in       = decode_q;
        execute_in.valid = decode_q.valid && !flush_mem;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controllers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    interrupt_storage unit_interrupt_storage(.clk(clk), .reset(reset),
        .clear(int_accept), .lines_in(external_interrupt), .pending(int_pending));

    main_forwarder unit_forwarder(.decode_in(decode_q), .mem_stage(execute_q),
        .wb_stage(memory_q), .fwd_a(fwd_a), .fwd_b(fwd_b));

    pipeline_flow_controller unit_flow_controller(.clk(clk), .reset(reset),
        .fetch_in(fetch_q), .decode_in(decode_q),
        .redirect(redirect), .target(target),
        .mem_stage(execute_q), .data_busy(data_busy),
        .int_pending(int_pending), .int_accept(int_accept),
        .stall_front(stall_front), .stall_all(stall_all),
        .flush_young(flush_young), .flush_mem(flush_mem),
        .load_pc(load_pc), .pc_value(pc_value));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    stage_fetch unit_fetch(.clk(clk), .reset(reset),
        .stall(stall_front | stall_all), .flush(flush_young),
        .load(load_pc), .pc_in(pc_value),
        .instr_addr(instr_addr), .instr_data(instr_data), .fetch_out(fetch_q));

    // a load-use hold leaves a bubble behind in the decode register.
    stage_decode unit_decode(.clk(clk), .reset(reset),
        .stall(stall_all), .flush(flush_young | stall_front),
        .fetch_in(fetch_q), .wb_in(memory_q), .decode_out(decode_q));

    stage_execute unit_execute(.clk(clk), .reset(reset), .stall(stall_all),
        .decode_in(execute_in), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd(execute_q), .wb_fwd(memory_q),
        .redirect(redirect), .target(target), .execute_out(execute_q));

    stage_memory unit_memory(.clk(clk), .reset(reset),
        .stall(stall_all), .cancel(flush_mem),
        .execute_in(execute_q), .data_req(data_req),
        .data_rdata(data_rdata), .memory_out(memory_q));

endmodule

// ==== verif/core_tb.sv ====
`timescale 1ns/1ps

module core_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int reset_cycles = 16;
    localparam int ctrl_base    = 'h80;
    localparam int expect_base  = 'h90;
    localparam int run_limit    = 4000;

    logic                 clk;
    logic                 reset;
    logic [int_lines-1:0] external_interrupt;
    word_t                instr_addr;
    word_t                instr_data;
    data_req_t            data_req;
    word_t                data_rdata;
    logic                 data_busy;

    word_t stim [0:255];
    word_t ram [0:255];
    word_t rand_state;
    int    edge_count;
    int    int_cycle;
    int    store_count;
    int    store_idx;
    int    handler_stores;
    word_t marker_addr;
    word_t marker_data;
    word_t done_addr;
    logic  done_seen;

    core dut_i (
        .clk                (clk),
        .reset              (reset),
        .external_interrupt (external_interrupt),
        .instr_addr         (instr_addr),
        .instr_data         (instr_data),
        .data_req           (data_req),
        .data_rdata         (data_rdata),
        .data_busy          (data_busy)
    );

    // both memories answer in the same cycle as the address.
    assign instr_data = stim[instr_addr[8:2]];
    assign data_rdata = ram[data_req.addr[9:2]];

    function automatic word_t next_random(input word_t state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t got);
        if (got !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0d ns: %s expected %h got %h",
                $time, name, expected, got));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // store tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic record_store(input word_t addr, input word_t data);
        if (addr == marker_addr) begin
            handler_stores = handler_stores + 1;
            if (handler_stores > 1) begin
                stop_with_failure("the interrupt handler stored its marker more than once");
            end
            check_value("handler store data", marker_data, data);
        end else if (store_idx >= store_count) begin
            stop_with_failure($sformatf("unexpected store to %h after the expected list",
                addr));
        end else begin
            check_value("store addr", stim[expect_base + 2 * store_idx], addr);
            check_value("store data", stim[expect_base + 2 * store_idx + 1], data);
            if (addr == done_addr) begin
                done_seen = 1'b1;
            end
            store_idx = store_idx + 1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset release, random back-pressure and the interrupt line all move just after the edge.
    always @(posedge clk) begin
        #5;
        edge_count = edge_count + 1;
        if (edge_count >= reset_cycles) begin
            reset      = 1'b0;
            rand_state = next_random(rand_state);
            data_busy  = (rand_state[31:30] == 2'b00);
            if (edge_count - reset_cycles == int_cycle) begin
                external_interrupt[2] = 1'b1;
            end
        end
    end

    // an access completes at the next edge when busy is low.
    always @(negedge clk) begin
        if (!reset && data_req.valid && !data_busy && data_req.write) begin
            if (data_req.addr[31:10] != '0) begin
                stop_with_failure($sformatf("store address %h lies outside the data RAM",
                    data_req.addr));
            end
            ram[data_req.addr[9:2]] = data_req.wdata;
            record_store(data_req.addr, data_req.wdata);
        end
    end

    initial begin
        int i;
        reset              = 1'b1;
        external_interrupt = '0;
        data_busy          = 1'b0;
        edge_count         = 0;
        store_idx          = 0;
        handler_stores     = 0;
        done_seen          = 1'b0;
        rand_state         = 32'd49213;
        for (i = 0; i < 256; i++) begin
            ram[i] = 32'hda7a_0000 + word_t'(i * 4);
        end
        $readmemh("verif/core_stim.txt", stim);
        int_cycle   = int'(stim[ctrl_base]);
        store_count = int'(stim[ctrl_base + 1]);
        marker_addr = stim[ctrl_base + 2];
        marker_data = stim[ctrl_base + 3];
        done_addr   = stim[ctrl_base + 4];

        for (i = 0; i < 4 * reset_cycles && reset; i++) begin
            @(negedge clk);
        end
        if (reset) begin
            stop_with_failure("reset was never released");
        end
        check_value("instr_addr", 32'h0000_0000, instr_addr);
        check_value("data_req.valid", 32'd0, {31'd0, data_req.valid});

        for (i = 0; i < run_limit && !done_seen; i++) begin
            @(negedge clk);
        end
        if (!done_seen) begin
            stop_with_failure("timeout waiting for the store to the done address");
        end

        // the program spins after the done store, so any later store is an error.
        repeat (10) @(negedge clk);
        if (store_idx == store_count && handler_stores == 1) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_with_failure($sformatf("run ended with %0d of %0d stores and %0d handler stores",
                store_idx, store_count, handler_stores));
        end
    end

endmodule

// ==== compile.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/stage_fetch.sv
source/stage_decode.sv
source/stage_execute.sv
source/stage_memory.sv
source/main_forwarder.sv
source/pipeline_flow_controller.sv
source/interrupt_storage.sv
source/core.sv
verif/core_tb.sv

// ==== verif/core_stim.txt ====
// hex words with several on a line, and each @ line sets the word index.
// 000 main program, 040 interrupt handler, 080 run control, 090 expected address and data pairs.
@000
24010005 24020007 00221821 00612023  // addiu addiu addu subu
AC030010 AC040014 3C051234 00A43025  // sw sw lui or
00C33824 0083402A AC060018 AC07001C  // and slt sw sw
AC080020 8C090018 01285021 AC0A0024  // sw lw then dependent addu and sw
11040001 AC010028 15000001 AC00002C  // beq not taken then sw and bne taken over a sw
10210001 AC000038 08000018 AC00003C  // beq taken over a sw then j over a sw
00015823 0161602A AC0B0030 AC0C0034  // subu slt sw sw
240D0001 AC0D00FC 0800001E 00000000  // done flag and its store then spin
00000000
@040
3C1ACAFE AC1A0080 42000018 00000000  // handler loads the marker and stores it before eret
00000000
@080
// interrupt cycle after reset, main store count, marker address, marker word, done address
0000000E 0000000A 00000080 CAFE0000 000000FC
@090
00000010 0000000C
00000014 00000007
00000018 12340007
0000001C 00000004
00000020 00000001
00000024 12340008
00000028 00000005
00000030 FFFFFFFB
00000034 00000001
000000FC 00000001
